// ==== log2_max_abs.sv ====
`timescale 1ns/1ps
`include "mx_cast_macros.svh"

module log2_max_abs (
  input  logic                     clk,
  input  logic                     reset,
  input  mx_format_pkg::in_block_t block,
  input  logic                     load,
  input  logic                     pop,
  output mx_stage_pkg::log2_t      log2,
  output logic                     valid
);

  localparam int N = `MX_BLOCK_SIZE;
  localparam int MAG_W = `MX_IN_MAN_W; // 128 still fits as an unsigned value

  // Heap layout, leaves sit at N-1 .. 2N-2 and the root at 0
  logic [MAG_W-1:0] node [2*N-1];
  mx_stage_pkg::log2_t pos;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      if (block.man[i][MAG_W-1]) begin
        node[N-1+i] = ~block.man[i] + 1'b1; // Two's complement negate
      end else begin
        node[N-1+i] = block.man[i];
      end
    end
    for (int k = N - 2; k >= 0; k--) begin
      if (node[2*k+1] >= node[2*k+2]) begin
        node[k] = node[2*k+1];
      end else begin
        node[k] = node[2*k+2];
      end
    end
  end

  // Later bits overwrite earlier ones so the highest set bit wins
  always_comb begin
    pos = '0;
    for (int b = 0; b < MAG_W; b++) begin
      if (node[0][b]) begin
        pos = mx_stage_pkg::log2_t'(b);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1; // A load in the same cycle as a pop keeps the stage full
    end else if (pop) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      log2 <= pos;
    end
  end

endmodule

// ==== mx_block_fifo.sv ====
`timescale 1ns/1ps
`include "mx_cast_macros.svh"

module mx_block_fifo (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     push,
  input  logic                     pop,
  input  mx_format_pkg::in_block_t din,
  output mx_format_pkg::in_block_t dout,
  output logic                     full,
  output logic                     nonempty
);

  localparam int DEPTH = `MX_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  mx_format_pkg::in_block_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign full = (count == CNT_W'(DEPTH));
  assign nonempty = (count != '0);
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

// ==== mx_cast_ctrl.sv ====
`timescale 1ns/1ps

module mx_cast_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_valid,
  output logic                      in_ready,
  output logic                      l2_load,
  input  logic                      l2_valid,
  output logic                      fifo_push,
  output logic                      fifo_pop,
  input  logic                      fifo_full,
  input  logic                      fifo_nonempty,
  input  mx_format_pkg::out_block_t result,
  output mx_format_pkg::out_block_t out_block,
  output logic                      out_valid,
  input  logic                      out_ready
);

  logic out_free;
  logic accept;

  // The output register can take a new block when empty or drained this cycle
  assign out_free = !out_valid || out_ready;

  // Join of the scale path and the buffered block
  assign fifo_pop = l2_valid && fifo_nonempty && out_free;

  // The log2 stage holds one block, so a new one enters only as the old one leaves
  assign in_ready = !fifo_full && (!l2_valid || fifo_pop);

  assign accept = in_valid && in_ready;

  // Split: both paths take the block on the same edge
  assign l2_load = accept;
  assign fifo_push = accept;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (fifo_pop) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      out_block <= result; // Held while out_ready is low
    end
  end

endmodule

// ==== mx_cast_macros.svh ====
`ifndef MX_CAST_MACROS_SVH
`define MX_CAST_MACROS_SVH

// Input format
`define MX_IN_MAN_W 8
`define MX_IN_EXP_W 8

// Output format
`define MX_OUT_MAN_W 4
`define MX_OUT_EXP_W 6

`define MX_BLOCK_SIZE 4

// Wide enough for bit positions of a magnitude up to 128
`define MX_LOG2_W 4

// Blocks buffered while their scale is computed
`define MX_FIFO_DEPTH 2

`endif

// ==== mx_exp_align.sv ====
`timescale 1ns/1ps
`include "mx_cast_macros.svh"

module mx_exp_align (
  input  mx_format_pkg::in_exp_t    in_exp,
  input  mx_stage_pkg::log2_t       log2,
  output mx_stage_pkg::align_rec_t  rec
);

  // Two spare bits cover the sum of exponent, position and bias
  localparam int RAW_W = `MX_IN_EXP_W + 2;

  localparam logic signed [RAW_W-1:0] BIAS = RAW_W'(`MX_OUT_MAN_W - 2);
  localparam logic signed [RAW_W-1:0] EXP_MAX = RAW_W'((1 << (`MX_OUT_EXP_W - 1)) - 1);
  localparam logic signed [RAW_W-1:0] EXP_MIN = -RAW_W'(1 << (`MX_OUT_EXP_W - 1));

  logic signed [RAW_W-1:0] exp_ext;
  logic signed [RAW_W-1:0] log2_ext;
  logic signed [RAW_W-1:0] raw_exp;
  mx_format_pkg::out_exp_t new_exp;

  assign exp_ext = RAW_W'(in_exp);
  assign log2_ext = RAW_W'(log2); // log2 is unsigned so this zero extends
  assign raw_exp = exp_ext + log2_ext - BIAS;

  always_comb begin
    if (raw_exp > EXP_MAX) begin
      new_exp = mx_format_pkg::out_exp_t'(EXP_MAX);
    end else if (raw_exp < EXP_MIN) begin
      new_exp = mx_format_pkg::out_exp_t'(EXP_MIN);
    end else begin
      new_exp = mx_format_pkg::out_exp_t'(raw_exp);
    end
  end

  assign rec.exp = new_exp;
  assign rec.shift = mx_stage_pkg::shift_t'(new_exp) - mx_stage_pkg::shift_t'(in_exp);

endmodule

// ==== mx_format_pkg.sv ====
`include "mx_cast_macros.svh"

package mx_format_pkg;

  typedef logic signed [`MX_IN_MAN_W-1:0] in_man_t;
  typedef logic signed [`MX_IN_EXP_W-1:0] in_exp_t;

  typedef logic signed [`MX_OUT_MAN_W-1:0] out_man_t;
  typedef logic signed [`MX_OUT_EXP_W-1:0] out_exp_t;

  // One shared exponent per block of mantissas
  typedef struct packed {
    in_man_t [`MX_BLOCK_SIZE-1:0] man;
    in_exp_t                      exp;
  } in_block_t;

  typedef struct packed {
    out_man_t [`MX_BLOCK_SIZE-1:0] man;
    out_exp_t                      exp;
  } out_block_t;

endpackage

// ==== mx_man_shift.sv ====
`timescale 1ns/1ps
`include "mx_cast_macros.svh"

module mx_man_shift (
  input  mx_format_pkg::in_block_t   block,
  input  mx_stage_pkg::align_rec_t   rec,
  output mx_format_pkg::out_block_t  out_block
);

  // Room for an input mantissa shifted left by less than the output width
  localparam int WIDE_W = `MX_IN_MAN_W + `MX_OUT_MAN_W;
  localparam int SHIFT_W = $bits(mx_stage_pkg::shift_t);

  localparam logic signed [WIDE_W-1:0] MAN_MAX = WIDE_W'((1 << (`MX_OUT_MAN_W - 1)) - 1);
  localparam logic signed [WIDE_W-1:0] MAN_MIN = -WIDE_W'(1 << (`MX_OUT_MAN_W - 1));

  always_comb begin
    logic signed [WIDE_W-1:0] wide;
    logic signed [WIDE_W-1:0] shifted;
    logic [SHIFT_W-1:0] amt;

    out_block.exp = rec.exp;

    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      wide = WIDE_W'($signed(block.man[i]));
      if (!rec.shift[SHIFT_W-1]) begin
        amt = rec.shift;
        if (amt >= SHIFT_W'(`MX_IN_MAN_W)) begin
          shifted = {WIDE_W{wide[WIDE_W-1]}}; // Everything shifted out
        end else begin
          shifted = wide >>> amt; // Truncates toward negative infinity
        end
      end else begin
        amt = -rec.shift;
        if (wide == '0) begin
          shifted = '0;
        end else if (amt >= SHIFT_W'(`MX_OUT_MAN_W)) begin
          // Any nonzero value overflows the output range here
          shifted = wide[WIDE_W-1] ? MAN_MIN : MAN_MAX;
        end else begin
          shifted = wide <<< amt;
        end
      end

      if (shifted > MAN_MAX) begin
        out_block.man[i] = mx_format_pkg::out_man_t'(MAN_MAX);
      end else if (shifted < MAN_MIN) begin
        out_block.man[i] = mx_format_pkg::out_man_t'(MAN_MIN);
      end else begin
        out_block.man[i] = mx_format_pkg::out_man_t'(shifted);
      end
    end
  end

endmodule

// ==== mx_stage_pkg.sv ====
`include "mx_cast_macros.svh"

package mx_stage_pkg;

  // Highest set bit of the largest magnitude, 0 when the block is all zero
  typedef logic [`MX_LOG2_W-1:0] log2_t;

  // New exponent minus old exponent, a positive value shifts right
  typedef logic signed [8:0] shift_t;

  typedef struct packed {
    mx_format_pkg::out_exp_t exp;
    shift_t                  shift;
  } align_rec_t;

endpackage

// ==== mxint_cast.sv ====
`timescale 1ns/1ps

module mxint_cast (
  input  logic                      clk,
  input  logic                      reset,
  input  mx_format_pkg::in_block_t  in_block,
  input  logic                      in_valid,
  output logic                      in_ready,
  output mx_format_pkg::out_block_t out_block,
  output logic                      out_valid,
  input  logic                      out_ready
);

  logic l2_load;
  logic l2_valid;
  mx_stage_pkg::log2_t l2_value;

  logic fifo_push;
  logic fifo_pop;
  logic fifo_full;
  logic fifo_nonempty;
  mx_format_pkg::in_block_t fifo_head;

  mx_stage_pkg::align_rec_t align_rec;
  mx_format_pkg::out_block_t result;

  mx_cast_ctrl ctrl0 (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .l2_load       (l2_load),
    .l2_valid      (l2_valid),
    .fifo_push     (fifo_push),
    .fifo_pop      (fifo_pop),
    .fifo_full     (fifo_full),
    .fifo_nonempty (fifo_nonempty),
    .result        (result),
    .out_block     (out_block),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

  // Scale path
  log2_max_abs log2_0 (
    .clk   (clk),
    .reset (reset),
    .block (in_block),
    .load  (l2_load),
    .pop   (fifo_pop),
    .log2  (l2_value),
    .valid (l2_valid)
  );

  // Data path waits here for its scale
  mx_block_fifo fifo0 (
    .clk      (clk),
    .reset    (reset),
    .push     (fifo_push),
    .pop      (fifo_pop),
    .din      (in_block),
    .dout     (fifo_head),
    .full     (fifo_full),
    .nonempty (fifo_nonempty)
  );

  mx_exp_align align0 (
    .in_exp (fifo_head.exp),
    .log2   (l2_value),
    .rec    (align_rec)
  );

  mx_man_shift shift0 (
    .block     (fifo_head),
    .rec       (align_rec),
    .out_block (result)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mxint_cast \
    --Mdir obj_dir -o tb_mxint_cast &&
  ./obj_dir/tb_mxint_cast | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+.
mx_format_pkg.sv
mx_stage_pkg.sv
log2_max_abs.sv
mx_block_fifo.sv
mx_exp_align.sv
mx_man_shift.sv
mx_cast_ctrl.sv
mxint_cast.sv
tb_mxint_cast.sv

// ==== tb_mxint_cast.sv ====
`timescale 1ns/1ps
`include "mx_cast_macros.svh"

module tb_mxint_cast;

  localparam int NUM_BLOCKS = 307; // Every block sent by the five tests
  localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 20 + 200;
  localparam int MAN_MAX = (1 << (`MX_OUT_MAN_W - 1)) - 1;
  localparam int MAN_MIN = -(1 << (`MX_OUT_MAN_W - 1));
  localparam int EXP_MAX = (1 << (`MX_OUT_EXP_W - 1)) - 1;
  localparam int EXP_MIN = -(1 << (`MX_OUT_EXP_W - 1));

  logic clk = 1'b0;
  logic reset;
  mx_format_pkg::in_block_t in_block;
  logic in_valid;
  logic in_ready;
  mx_format_pkg::out_block_t out_block;
  logic out_valid;
  logic out_ready;

  mx_format_pkg::out_block_t exp_q[$];
  mx_format_pkg::out_block_t last_out;
  mx_format_pkg::out_block_t held_block;
  logic held_valid = 1'b0;
  logic stall_seen;
  logic bp_done;
  int unsigned lcg_state = 53;
  int errors = 0;
  int checks = 0;
  int sent_count = 0;
  int recv_count = 0;

  mxint_cast dut0 (
    .clk       (clk),
    .reset     (reset),
    .in_block  (in_block),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_block (out_block),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #2 clk = ~clk;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Expected result worked out in plain integers from the format rules
  function automatic mx_format_pkg::out_block_t ref_cast(input mx_format_pkg::in_block_t b);
    mx_format_pkg::out_block_t r;
    mx_format_pkg::in_man_t m;
    mx_format_pkg::in_exp_t old_exp;
    int mag_max;
    int pos;
    int e;
    int sh;
    int v;
    int a;
    mag_max = 0;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      m = b.man[i];
      a = (m < 0) ? -int'(m) : int'(m);
      if (a > mag_max) mag_max = a;
    end
    pos = 0;
    for (int k = 0; k < `MX_IN_MAN_W; k++) begin
      if (mag_max >= (1 << k)) pos = k;
    end
    old_exp = b.exp;
    e = int'(old_exp) + pos - (`MX_OUT_MAN_W - 2);
    if (e > EXP_MAX) e = EXP_MAX;
    else if (e < EXP_MIN) e = EXP_MIN;
    sh = e - int'(old_exp);
    r.exp = mx_format_pkg::out_exp_t'(e);
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      m = b.man[i];
      v = int'(m);
      if (sh >= 0) begin
        v = v >>> ((sh > 31) ? 31 : sh); // Floor division by a power of two
      end else begin
        a = (-sh > 8) ? 8 : -sh;
        v = v * (1 << a);
      end
      if (v > MAN_MAX) v = MAN_MAX;
      else if (v < MAN_MIN) v = MAN_MIN;
      r.man[i] = mx_format_pkg::out_man_t'(v);
    end
    return r;
  endfunction

  function automatic mx_format_pkg::in_block_t make_block(input int m0, input int m1,
                                                          input int m2, input int m3,
                                                          input int e);
    mx_format_pkg::in_block_t b;
    b.man[0] = mx_format_pkg::in_man_t'(m0);
    b.man[1] = mx_format_pkg::in_man_t'(m1);
    b.man[2] = mx_format_pkg::in_man_t'(m2);
    b.man[3] = mx_format_pkg::in_man_t'(m3);
    b.exp = mx_format_pkg::in_exp_t'(e);
    return b;
  endfunction

  function automatic mx_format_pkg::in_block_t random_block();
    mx_format_pkg::in_block_t b;
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      b.man[i] = mx_format_pkg::in_man_t'(lcg_next());
    end
    b.exp = mx_format_pkg::in_exp_t'(int'(lcg_next() % 80) - 40); // Reaches both clamps
    return b;
  endfunction

  task automatic check_man(input mx_format_pkg::out_man_t got,
                           input mx_format_pkg::out_man_t expected, input string what);
    checks++;
    if (got !== expected) begin
      $display("[ERROR] %0t ns: %s mantissa is %0d, expected %0d", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic check_exp(input mx_format_pkg::out_exp_t got,
                           input mx_format_pkg::out_exp_t expected, input string what);
    checks++;
    if (got !== expected) begin
      $display("[ERROR] %0t ns: %s exponent is %0d, expected %0d", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic expected, input string what);
    checks++;
    if (got !== expected) begin
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic check_cycles(input int got, input int expected, input string what);
    checks++;
    if (got != expected) begin
      $display("[ERROR] %0t ns: %s is %0d cycles, expected %0d", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic check_block(input mx_format_pkg::out_block_t got,
                             input mx_format_pkg::out_block_t expected, input string what);
    for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
      check_man(got.man[i], expected.man[i], what);
    end
    check_exp(got.exp, expected.exp, what);
  endtask

  task automatic expect_last(input int m0, input int m1, input int m2, input int m3,
                             input int e, input string what);
    mx_format_pkg::out_block_t r;
    r.man[0] = mx_format_pkg::out_man_t'(m0);
    r.man[1] = mx_format_pkg::out_man_t'(m1);
    r.man[2] = mx_format_pkg::out_man_t'(m2);
    r.man[3] = mx_format_pkg::out_man_t'(m3);
    r.exp = mx_format_pkg::out_exp_t'(e);
    check_block(last_out, r, what);
  endtask

  // Called 1 ns after a rising edge and returns at the same point after the transfer
  task automatic send_block(input mx_format_pkg::in_block_t b);
    logic taken;
    taken = 1'b0;
    in_block = b;
    in_valid = 1'b1;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      if (!in_ready) stall_seen = 1'b1;
      @(posedge clk);
      #1;
    end
    exp_q.push_back(ref_cast(b));
    sent_count++;
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // Outputs are sampled at the falling edge half a cycle before the transfer edge
  always @(negedge clk) begin
    if (!reset) begin
      if (held_valid) begin
        check_flag(out_valid, 1'b1, "out_valid under back-pressure");
        check_block(out_block, held_block, "held output");
      end
      held_valid = out_valid && !out_ready;
      held_block = out_block;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("An output block arrived with none expected at %0t ns", $time);
          errors++;
        end else begin
          check_block(out_block, exp_q.pop_front(), "output block");
        end
        last_out = out_block;
        recv_count++;
      end
    end
  end

  task automatic test_after_reset();
    int cycles;
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(in_ready, 1'b1, "in_ready after reset");
    send_block(make_block(20, -12, 5, 0, 0));
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!out_valid);
    check_cycles(cycles, 2, "latency");
    drain();
    expect_last(5, -3, 1, 0, 2, "mid-range block");
  endtask

  task automatic test_exp_saturation();
    send_block(make_block(100, -90, 127, -128, 127));
    drain();
    expect_last(7, -8, 7, -8, 31, "exponent 127");
    send_block(make_block(100, -128, 50, -1, -128));
    drain();
    expect_last(0, -1, 0, -1, -32, "exponent -128");
  endtask

  task automatic test_man_saturation();
    send_block(make_block(3, -4, 1, 0, 33));
    drain();
    expect_last(7, -8, 4, 0, 31, "left shift overflow");
    send_block(make_block(127, -128, 1, -3, -40));
    drain();
    expect_last(0, -1, 0, -1, -32, "right shift by 8");
    send_block(make_block(-5, 64, 7, -1, 0));
    drain();
    expect_last(-1, 4, 0, -1, 4, "truncating right shift");
    send_block(make_block(0, 0, 0, 0, 10));
    drain();
    expect_last(0, 0, 0, 0, 8, "all-zero block");
  endtask

  task automatic test_streaming();
    stall_seen = 1'b0;
    for (int n = 0; n < 200; n++) begin
      send_block(random_block());
    end
    check_flag(stall_seen, 1'b0, "in_ready stall at full rate");
    drain();
  endtask

  task automatic test_back_pressure();
    stall_seen = 1'b0;
    bp_done = 1'b0;
    fork
      begin
        for (int n = 0; n < 100; n++) begin
          send_block(random_block());
        end
        bp_done = 1'b1;
      end
      begin
        while (!bp_done) begin
          out_ready = (lcg_next() % 2) != 0;
          @(posedge clk);
          #1;
        end
      end
    join
    out_ready = 1'b1;
    check_flag(stall_seen, 1'b1, "in_ready stall under back-pressure");
    drain();
  endtask

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_block = '0;
    out_ready = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    test_after_reset();
    test_exp_saturation();
    test_man_saturation();
    test_streaming();
    test_back_pressure();
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0 || recv_count != sent_count) begin
      $display("Blocks lost or duplicated: %0d sent, %0d received", sent_count, recv_count);
      errors++;
    end
    $display("Closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
